// File: logic/lc3b_isa_pkg.sv
`default_nettype none

package lc3b_isa_pkg;

	localparam int word_width = 16;
	localparam int reg_width = 3;
	localparam int opcode_width = 4;

	// Low bit of each instruction field
	localparam int opcode_lsb = 12;
	localparam int dest_lsb = 9;   // Also the store source
	localparam int sr1_lsb = 6;    // Also the base register
	localparam int sr2_lsb = 0;
	localparam int imm_sel_bit = 5;

	// Immediate and offset field widths, both start at bit 0
	localparam int imm5_width = 5;
	localparam int off6_width = 6;

	typedef logic [word_width-1:0] lc3b_word;
	typedef logic [reg_width-1:0] lc3b_reg;

	// Full LC-3b opcode map, unsupported ones are still recognised
	typedef enum logic [opcode_width-1:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

endpackage

`default_nettype wire

// File: logic/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

	// Reorder buffer
	localparam int rob_tag_width = 3;

	// ALU reservation stations
	localparam int num_alu_stations = 3;
	localparam int station_id_width = $clog2(num_alu_stations);

	typedef logic [rob_tag_width-1:0] rob_tag_t;
	typedef logic [station_id_width-1:0] station_id_t;

	// One busy bit per ALU station, bit i is station i
	typedef logic [num_alu_stations-1:0] station_mask_t;

	// Tag field value when an operand is already present
	localparam rob_tag_t no_tag = '0;

endpackage

`default_nettype wire

// File: logic/reg_lookup_if.sv
`default_nettype none

interface reg_lookup_if import lc3b_isa_pkg::*, tomasulo_pkg::*;
(
	input logic clk
);

	// Register file side
	logic reg_busy;
	lc3b_word reg_data;
	rob_tag_t reg_tag;

	// ROB copy of the pending result
	logic rob_valid;
	lc3b_word rob_value;

	// Common data bus broadcast
	logic cdb_valid;
	rob_tag_t cdb_tag;
	lc3b_word cdb_data;

	modport source (
		output reg_busy, reg_data, reg_tag,
		output rob_valid, rob_value,
		output cdb_valid, cdb_tag, cdb_data
	);

	modport resolver (
		input clk,
		input reg_busy, reg_data, reg_tag,
		input rob_valid, rob_value,
		input cdb_valid, cdb_tag, cdb_data
	);

endinterface

`default_nettype wire

// File: logic/instr_decoder.sv
`default_nettype none

module instr_decoder import lc3b_isa_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_word instr,
	output lc3b_opcode opcode,
	output lc3b_reg dest_reg,
	output lc3b_reg sr1_reg,
	output lc3b_reg sr2_reg,
	output logic imm_sel,
	output lc3b_word imm5_value,
	output lc3b_word mem_offset
);

	lc3b_word instr_q;
	logic [off6_width-1:0] off6;

	// Instruction word of the holding register
	always_ff @(posedge clk)
	begin
		if (reset)
			instr_q <= '0;
		else if (load)
			instr_q <= instr;
	end

	assign opcode = lc3b_opcode'(instr_q[opcode_lsb +: opcode_width]);
	assign dest_reg = instr_q[dest_lsb +: reg_width];
	assign sr1_reg = instr_q[sr1_lsb +: reg_width];
	assign sr2_reg = instr_q[sr2_lsb +: reg_width];

	// SHF always carries its amount in the low bits
	assign imm_sel = instr_q[imm_sel_bit] || (opcode == op_shf);

	assign imm5_value = {{(word_width - imm5_width){instr_q[imm5_width-1]}},
		instr_q[imm5_width-1:0]};

	assign off6 = instr_q[off6_width-1:0];

	always_comb
	begin
		case (opcode)
			// Byte accesses use the raw offset
			op_ldb, op_stb:
				mem_offset = {{(word_width - off6_width){off6[off6_width-1]}}, off6};
			// Word accesses scale by two
			default:
				mem_offset = {{(word_width - off6_width - 1){off6[off6_width-1]}}, off6, 1'b0};
		endcase
	end

endmodule

`default_nettype wire

// File: logic/operand_resolver.sv
`default_nettype none

module operand_resolver import lc3b_isa_pkg::*, tomasulo_pkg::*;
(
	reg_lookup_if.resolver lookup,
	output lc3b_word value,
	output rob_tag_t wait_tag,
	output logic ready
);

	logic cdb_hit;

	assign cdb_hit = lookup.cdb_valid && (lookup.cdb_tag == lookup.reg_tag);

	// Register file first, then CDB, then ROB, else wait
	always_comb
	begin
		value = '0;
		wait_tag = no_tag;
		ready = 1'b1;
		if (!lookup.reg_busy)
			value = lookup.reg_data;    // Not renamed
		else if (cdb_hit)
			value = lookup.cdb_data;    // Producer finishing this cycle
		else if (lookup.rob_valid)
			value = lookup.rob_value;   // Done but not yet committed
		else
		begin
			ready = 1'b0;
			wait_tag = lookup.reg_tag;
		end
	end

	// A broadcast is only picked up for a renamed register
	cdb_only_when_busy: assert property (@(posedge lookup.clk)
		(cdb_hit && !lookup.reg_busy) |-> (value == lookup.reg_data));

endmodule

`default_nettype wire

// File: logic/issue_control.sv
`default_nettype none

module issue_control import lc3b_isa_pkg::*, tomasulo_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic instr_valid,
	output logic instr_ready,
	output logic load,
	input lc3b_opcode opcode,
	input logic imm_sel,
	input station_mask_t alu_station_busy,
	input logic lsb_full,
	input logic rob_full,
	output logic rs_write,
	output station_id_t rs_station_id,
	output logic lsb_write,
	output logic rob_write,
	output logic rob_has_dest,
	output logic rename_write,
	output logic use_store_source
);

	typedef enum logic {
		st_empty,
		st_held
	} hold_state_t;

	hold_state_t state;
	hold_state_t state_next;

	logic is_alu;
	logic is_load;
	logic is_store;
	logic is_mem;
	logic held;
	logic blocked;
	logic issue;
	station_id_t free_id;

	assign is_alu = opcode inside {op_add, op_and, op_not, op_shf};
	assign is_load = opcode inside {op_ldr, op_ldb};
	assign is_store = opcode inside {op_str, op_stb};
	assign is_mem = is_load || is_store;

	assign held = (state == st_held);

	// Structural hazards, unsupported opcodes never wait
	assign blocked = held && (is_alu || is_mem) &&
		(rob_full || (is_alu && (&alu_station_busy)) || (is_mem && lsb_full));

	assign issue = held && !blocked;

	assign instr_ready = !held || issue;
	assign load = instr_valid && instr_ready;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= st_empty;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		if (load)
			state_next = st_held;      // Refill, possibly in the issue cycle
		else if (issue)
			state_next = st_empty;
	end

	// Lowest numbered idle station wins
	always_comb
	begin
		free_id = '0;
		for (int i = num_alu_stations - 1; i >= 0; i--)
		begin
			if (!alu_station_busy[i])
				free_id = station_id_t'(i);
		end
	end

	assign rs_station_id = free_id;

	assign rs_write = issue && is_alu;
	assign lsb_write = issue && is_mem;
	assign rob_write = issue && (is_alu || is_mem);
	assign rob_has_dest = is_alu || is_load;    // Stores retire without a register
	assign rename_write = issue && (is_alu || is_load);
	assign use_store_source = is_store;

	one_unit_per_issue: assert property (@(posedge clk) disable iff (reset)
		!(rs_write && lsb_write));

	rename_needs_rob: assert property (@(posedge clk) disable iff (reset)
		rename_write |-> rob_write);

	station_is_free: assert property (@(posedge clk) disable iff (reset)
		rs_write |-> !alu_station_busy[rs_station_id]);

	// Decoder must flag the shift amount as an immediate
	shift_uses_imm: assert property (@(posedge clk) disable iff (reset)
		(rs_write && (opcode == op_shf)) |-> imm_sel);

endmodule

`default_nettype wire

// File: logic/issue_unit.sv
`default_nettype none

module issue_unit import lc3b_isa_pkg::*, tomasulo_pkg::*;
(
	input logic clk,
	input logic reset,
	input lc3b_word instr,
	input logic instr_valid,
	output logic instr_ready,
	input logic cdb_valid,
	input rob_tag_t cdb_tag,
	input lc3b_word cdb_data,
	input station_mask_t alu_station_busy,
	input logic lsb_full,
	input logic rob_full,
	input rob_tag_t rob_tail,
	output lc3b_reg sr1_addr,
	output lc3b_reg sr2_addr,
	input logic sr1_busy,
	input lc3b_word sr1_data,
	input rob_tag_t sr1_tag,
	input logic sr2_busy,
	input lc3b_word sr2_data,
	input rob_tag_t sr2_tag,
	input logic rob_sr1_valid,
	input lc3b_word rob_sr1_value,
	input logic rob_sr2_valid,
	input lc3b_word rob_sr2_value,
	output logic rs_write,
	output station_id_t rs_station_id,
	output lc3b_opcode rs_op,
	output lc3b_word rs_vj,
	output rob_tag_t rs_qj,
	output logic rs_j_ready,
	output lc3b_word rs_vk,
	output rob_tag_t rs_qk,
	output logic rs_k_ready,
	output rob_tag_t rs_dest,
	output logic lsb_write,
	output lc3b_opcode lsb_op,
	output lc3b_word lsb_offset,
	output lc3b_word lsb_vbase,
	output rob_tag_t lsb_qbase,
	output logic lsb_base_ready,
	output lc3b_word lsb_vsrc,
	output rob_tag_t lsb_qsrc,
	output logic lsb_src_ready,
	output rob_tag_t lsb_dest,
	output logic rob_write,
	output lc3b_opcode rob_op,
	output lc3b_reg rob_dest_reg,
	output logic rob_has_dest,
	output logic rename_write,
	output lc3b_reg rename_reg,
	output rob_tag_t rename_tag
);

	logic load;
	lc3b_opcode opcode;
	lc3b_reg dest_reg;
	lc3b_reg sr1_reg;
	lc3b_reg sr2_reg;
	logic imm_sel;
	lc3b_word imm5_value;
	lc3b_word mem_offset;
	logic use_store_source;

	lc3b_word j_value;
	rob_tag_t j_tag;
	logic j_ready;
	lc3b_word k_value;
	rob_tag_t k_tag;
	logic k_ready;

	reg_lookup_if src1_lookup (.clk(clk));
	reg_lookup_if src2_lookup (.clk(clk));

	instr_decoder i_decoder (
		.clk(clk), .reset(reset), .load(load), .instr(instr),
		.opcode(opcode), .dest_reg(dest_reg), .sr1_reg(sr1_reg), .sr2_reg(sr2_reg),
		.imm_sel(imm_sel), .imm5_value(imm5_value), .mem_offset(mem_offset)
	);

	issue_control i_control (
		.clk(clk), .reset(reset),
		.instr_valid(instr_valid), .instr_ready(instr_ready), .load(load),
		.opcode(opcode), .imm_sel(imm_sel),
		.alu_station_busy(alu_station_busy), .lsb_full(lsb_full), .rob_full(rob_full),
		.rs_write(rs_write), .rs_station_id(rs_station_id), .lsb_write(lsb_write),
		.rob_write(rob_write), .rob_has_dest(rob_has_dest), .rename_write(rename_write),
		.use_store_source(use_store_source)
	);

	// Port 2 reads the store data register for STR/STB
	assign sr1_addr = sr1_reg;
	assign sr2_addr = use_store_source ? dest_reg : sr2_reg;

	assign src1_lookup.reg_busy = sr1_busy;
	assign src1_lookup.reg_data = sr1_data;
	assign src1_lookup.reg_tag = sr1_tag;
	assign src1_lookup.rob_valid = rob_sr1_valid;
	assign src1_lookup.rob_value = rob_sr1_value;
	assign src1_lookup.cdb_valid = cdb_valid;
	assign src1_lookup.cdb_tag = cdb_tag;
	assign src1_lookup.cdb_data = cdb_data;

	assign src2_lookup.reg_busy = sr2_busy;
	assign src2_lookup.reg_data = sr2_data;
	assign src2_lookup.reg_tag = sr2_tag;
	assign src2_lookup.rob_valid = rob_sr2_valid;
	assign src2_lookup.rob_value = rob_sr2_value;
	assign src2_lookup.cdb_valid = cdb_valid;
	assign src2_lookup.cdb_tag = cdb_tag;
	assign src2_lookup.cdb_data = cdb_data;

	operand_resolver i_resolve_j (
		.lookup(src1_lookup), .value(j_value), .wait_tag(j_tag), .ready(j_ready)
	);

	operand_resolver i_resolve_k (
		.lookup(src2_lookup), .value(k_value), .wait_tag(k_tag), .ready(k_ready)
	);

	assign rs_op = opcode;
	assign rs_vj = j_value;
	assign rs_qj = j_tag;
	assign rs_j_ready = j_ready;
	assign rs_vk = imm_sel ? imm5_value : k_value;   // Immediate is always present
	assign rs_qk = imm_sel ? no_tag : k_tag;
	assign rs_k_ready = imm_sel || k_ready;
	assign rs_dest = rob_tail;

	// Base on port 1, store data on port 2
	assign lsb_op = opcode;
	assign lsb_offset = mem_offset;
	assign lsb_vbase = j_value;
	assign lsb_qbase = j_tag;
	assign lsb_base_ready = j_ready;
	assign lsb_vsrc = k_value;
	assign lsb_qsrc = k_tag;
	assign lsb_src_ready = k_ready;
	assign lsb_dest = rob_tail;

	assign rob_op = opcode;
	assign rob_dest_reg = dest_reg;

	assign rename_reg = dest_reg;
	assign rename_tag = rob_tail;

endmodule

`default_nettype wire

// File: verif/issue_tasks.svh
`ifndef issue_tasks_svh
`define issue_tasks_svh

// Expected operand per source, index 0 is port 1
lc3b_word exp_value [2];
rob_tag_t exp_tag [2];
logic exp_ready [2];

task automatic next_cycle();
	@(posedge clk);
	#1;
endtask

task automatic compare_value(input string what, input int got, input int expected);
	if (got != expected)
	begin
		$display("Error at %0t: %s is %h, expected %h", $time, what, got, expected);
		error_count++;
	end
endtask

task automatic finish_test(input string name, input int start_errors);
	test_count++;
	if (error_count == start_errors)
		$display("Test %s: ok", name);
	else
		$display("Test %s: %0d errors", name, error_count - start_errors);
endtask

// Mode 0 register file, 1 CDB match, 2 ROB value, 3 wait on tag
task automatic drive_source(input int src, input int mode);
	logic busy;
	logic rob_v;
	lc3b_word data;
	lc3b_word rob_val;
	rob_tag_t tag;
	busy = (mode != 0);
	rob_v = (mode == 1 || mode == 2);    // CDB has to win over this copy
	data = random_bits(16);
	rob_val = random_bits(16);
	tag = cdb_tag ^ rob_tag_t'(random_bits(2) + 1);
	if (mode <= 1)
		tag = cdb_tag;                   // Live CDB match ignored when not busy
	exp_ready[src] = (mode != 3);
	exp_tag[src] = (mode == 3) ? tag : no_tag;
	case (mode)
		0: exp_value[src] = data;
		1: exp_value[src] = cdb_data;
		2: exp_value[src] = rob_val;
		default: exp_value[src] = '0;
	endcase
	if (src == 0)
	begin
		sr1_busy = busy;
		sr1_data = data;
		sr1_tag = tag;
		rob_sr1_valid = rob_v;
		rob_sr1_value = rob_val;
	end
	else
	begin
		sr2_busy = busy;
		sr2_data = data;
		sr2_tag = tag;
		rob_sr2_valid = rob_v;
		rob_sr2_value = rob_val;
	end
endtask

task automatic drive_lookups(input int mode_j, input int mode_k);
	cdb_valid = 1'b1;
	cdb_tag = rob_tag_t'(random_bits(3));
	cdb_data = random_bits(16);
	rob_tail = rob_tag_t'(random_bits(3));
	drive_source(0, mode_j);
	drive_source(1, mode_k);
endtask

// Offer one word, return at the drive point after the transfer edge
task automatic send_instr(input lc3b_word word);
	int waited;
	waited = 0;
	instr = word;
	instr_valid = 1'b1;
	#4;
	while (!instr_ready && waited < issue_limit)
	begin
		next_cycle();
		#4;
		waited++;
	end
	if (!instr_ready)
	begin
		$display("Instruction %h was never accepted", word);
		error_count++;
	end
	next_cycle();
	instr_valid = 1'b0;
endtask

task automatic wait_issue(output int waited);
	waited = 0;
	#4;
	while (!rob_write && waited < issue_limit)
	begin
		next_cycle();
		#4;
		waited++;
	end
	if (!rob_write)
	begin
		$display("Instruction did not issue within %0d cycles", issue_limit);
		error_count++;
	end
endtask

task automatic confirm_no_writes();
	compare_value("rs_write", int'(rs_write), 0);
	compare_value("lsb_write", int'(lsb_write), 0);
	compare_value("rob_write", int'(rob_write), 0);
	compare_value("rename_write", int'(rename_write), 0);
endtask

task automatic check_operand(input string name, input lc3b_word v, input rob_tag_t q,
	input logic r, input int src);
	compare_value({name, " ready"}, int'(r), int'(exp_ready[src]));
	compare_value({name, " tag"}, int'(q), int'(exp_tag[src]));
	if (exp_ready[src])
		compare_value({name, " value"}, int'(v), int'(exp_value[src]));
endtask

// Kind 0 ALU, 1 load, 2 store
task automatic verify_issue_fields(input int kind, input lc3b_word word);
	compare_value("rs_write", int'(rs_write), int'(kind == 0));
	compare_value("lsb_write", int'(lsb_write), int'(kind != 0));
	compare_value("rob_write", int'(rob_write), 1);
	compare_value("rob_has_dest", int'(rob_has_dest), int'(kind != 2));
	compare_value("rename_write", int'(rename_write), int'(kind != 2));
	compare_value("rob_op", int'(rob_op), int'(word[15:12]));
	compare_value("rob_dest_reg", int'(rob_dest_reg), int'(word[11:9]));
	compare_value("sr1_addr", int'(sr1_addr), int'(word[8:6]));
	compare_value("sr2_addr", int'(sr2_addr), int'(kind == 2 ? word[11:9] : word[2:0]));
	if (kind != 2)
	begin
		compare_value("rename_reg", int'(rename_reg), int'(word[11:9]));
		compare_value("rename_tag", int'(rename_tag), int'(rob_tail));
	end
	if (kind == 0)
	begin
		compare_value("rs_op", int'(rs_op), int'(word[15:12]));
		compare_value("rs_dest", int'(rs_dest), int'(rob_tail));
	end
	else
	begin
		compare_value("lsb_op", int'(lsb_op), int'(word[15:12]));
		compare_value("lsb_dest", int'(lsb_dest), int'(rob_tail));
	end
endtask

// No hazard, so the issue has to follow acceptance directly
task automatic issue_one(input lc3b_word word, input int kind, input int mode_j,
	input int mode_k);
	int waited;
	send_instr(word);
	drive_lookups(mode_j, mode_k);
	wait_issue(waited);
	compare_value("cycles to issue", waited, 0);
	verify_issue_fields(kind, word);
endtask

task automatic idle_after_reset();
	int start_errors;
	start_errors = error_count;
	#4;
	confirm_no_writes();
	compare_value("instr_ready", int'(instr_ready), 1);
	next_cycle();
	finish_test("reset and idle", start_errors);
endtask

task automatic alu_register_issue();
	lc3b_word words [4] = '{16'h1642, 16'h1185, 16'h1E84, 16'h1B41};
	station_mask_t masks [4] = '{3'b000, 3'b001, 3'b011, 3'b101};
	int stations [4] = '{0, 1, 2, 1};
	int start_errors;
	start_errors = error_count;
	for (int i = 0; i < 4; i++)
	begin
		alu_station_busy = masks[i];
		issue_one(words[i], 0, i, (i + 1) % 4);
		compare_value("rs_station_id", int'(rs_station_id), stations[i]);
		check_operand("rs j", rs_vj, rs_qj, rs_j_ready, 0);
		check_operand("rs k", rs_vk, rs_qk, rs_k_ready, 1);
		next_cycle();
	end
	alu_station_busy = '0;
	finish_test("ALU register issue", start_errors);
endtask

// AND #-7, SHF RSHFL #6, LDB #-3, LDR #13
task automatic immediate_operands();
	lc3b_word words [4] = '{16'h59B9, 16'hD556, 16'h22BD, 16'h6A0D};
	lc3b_word expected [4] = '{16'hFFF9, 16'hFFF6, 16'hFFFD, 16'h001A};
	int start_errors;
	start_errors = error_count;
	for (int i = 0; i < 4; i++)
	begin
		issue_one(words[i], (i < 2) ? 0 : 1, i, 3);
		if (i < 2)
		begin
			exp_value[1] = expected[i];    // Immediate overrides the waiting source
			exp_tag[1] = no_tag;
			exp_ready[1] = 1'b1;
			check_operand("rs k", rs_vk, rs_qk, rs_k_ready, 1);
		end
		else
		begin
			compare_value("lsb_offset", int'(lsb_offset), int'(expected[i]));
			check_operand("lsb base", lsb_vbase, lsb_qbase, lsb_base_ready, 0);
		end
		next_cycle();
	end
	finish_test("immediates", start_errors);
endtask

// STR R7, R3, #5 and STB R2, R4, #-1
task automatic store_issue();
	lc3b_word words [2] = '{16'h7EC5, 16'h353F};
	lc3b_word offsets [2] = '{16'h000A, 16'hFFFF};
	int start_errors;
	start_errors = error_count;
	for (int i = 0; i < 2; i++)
	begin
		issue_one(words[i], 2, 2 * i, 3 - 2 * i);
		compare_value("lsb_offset", int'(lsb_offset), int'(offsets[i]));
		check_operand("lsb base", lsb_vbase, lsb_qbase, lsb_base_ready, 0);
		check_operand("lsb source", lsb_vsrc, lsb_qsrc, lsb_src_ready, 1);
		next_cycle();
	end
	finish_test("stores", start_errors);
endtask

task automatic back_pressure();
	lc3b_word words [3] = '{16'h1642, 16'h6A0D, 16'h7EC5};
	int start_errors;
	int waited;
	start_errors = error_count;
	for (int h = 0; h < 3; h++)
	begin
		alu_station_busy = (h == 0) ? 3'b111 : 3'b000;
		lsb_full = (h == 1);
		rob_full = (h == 2);
		send_instr(words[h]);
		drive_lookups(0, 0);
		repeat (3)
		begin
			#4;
			confirm_no_writes();
			compare_value("instr_ready while stalled", int'(instr_ready), 0);
			next_cycle();
		end
		alu_station_busy = 3'b011;    // Station 2 left free
		lsb_full = 1'b0;
		rob_full = 1'b0;
		wait_issue(waited);
		compare_value("cycles after release", waited, 0);
		verify_issue_fields(h, words[h]);
		next_cycle();
	end
	alu_station_busy = '0;
	finish_test("back-pressure", start_errors);
endtask

// BRnzp is consumed while ADD and LDB follow on consecutive edges
task automatic dropped_then_back_to_back();
	int start_errors;
	start_errors = error_count;
	send_instr(16'h0E05);
	drive_lookups(0, 2);
	instr = 16'h1642;
	instr_valid = 1'b1;
	#4;
	confirm_no_writes();
	compare_value("instr_ready with BR held", int'(instr_ready), 1);
	next_cycle();
	instr = 16'h22BD;
	#4;
	verify_issue_fields(0, 16'h1642);
	check_operand("rs k", rs_vk, rs_qk, rs_k_ready, 1);
	compare_value("instr_ready during issue", int'(instr_ready), 1);
	next_cycle();
	instr_valid = 1'b0;
	#4;
	verify_issue_fields(1, 16'h22BD);
	compare_value("lsb_offset", int'(lsb_offset), 'hFFFD);
	next_cycle();
	finish_test("dropped opcode and back-to-back", start_errors);
endtask

`endif

// File: verif/issue_unit_tb.sv
`default_nettype none

module issue_unit_tb import lc3b_isa_pkg::*, tomasulo_pkg::*;;

	localparam int issue_limit = 8;        // Cycles allowed from acceptance to issue
	localparam int watchdog_time = 2000;   // About six times the length of all tests

	logic clk;
	logic reset;
	lc3b_word instr;
	logic instr_valid, instr_ready;
	logic cdb_valid;
	rob_tag_t cdb_tag;
	lc3b_word cdb_data;
	station_mask_t alu_station_busy;
	logic lsb_full, rob_full;
	rob_tag_t rob_tail;
	lc3b_reg sr1_addr, sr2_addr;
	logic sr1_busy, sr2_busy;
	lc3b_word sr1_data, sr2_data;
	rob_tag_t sr1_tag, sr2_tag;
	logic rob_sr1_valid, rob_sr2_valid;
	lc3b_word rob_sr1_value, rob_sr2_value;
	logic rs_write, rs_j_ready, rs_k_ready;
	station_id_t rs_station_id;
	lc3b_opcode rs_op, lsb_op, rob_op;
	lc3b_word rs_vj, rs_vk, lsb_offset, lsb_vbase, lsb_vsrc;
	rob_tag_t rs_qj, rs_qk, rs_dest, lsb_qbase, lsb_qsrc, lsb_dest, rename_tag;
	logic lsb_write, lsb_base_ready, lsb_src_ready;
	logic rob_write, rob_has_dest, rename_write;
	lc3b_reg rob_dest_reg, rename_reg;

	int error_count;
	int test_count;
	logic [15:0] lfsr_state = 16'd99;

	issue_unit i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [15:0] random_bits(input int count);
		logic [15:0] result;
		logic feedback;
		result = '0;
		for (int i = 0; i < count; i++)
		begin
			feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], feedback};
			result = {result[14:0], feedback};
		end
		return result;
	endfunction

	`include "issue_tasks.svh"

	initial
	begin
		#watchdog_time;
		$display("Timeout: tests still running after %0d time units", watchdog_time);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		error_count = 0;
		test_count = 0;
		reset = 1'b1;
		instr = '0;
		instr_valid = 1'b0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		alu_station_busy = '0;
		lsb_full = 1'b0;
		rob_full = 1'b0;
		rob_tail = '0;
		sr1_busy = 1'b0;
		sr1_data = '0;
		sr1_tag = '0;
		sr2_busy = 1'b0;
		sr2_data = '0;
		sr2_tag = '0;
		rob_sr1_valid = 1'b0;
		rob_sr1_value = '0;
		rob_sr2_valid = 1'b0;
		rob_sr2_value = '0;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		idle_after_reset();
		alu_register_issue();
		immediate_operands();
		store_issue();
		back_pressure();
		dropped_then_back_to_back();
		$display("Tests run: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+verif
logic/lc3b_isa_pkg.sv
logic/tomasulo_pkg.sv
logic/reg_lookup_if.sv
logic/instr_decoder.sv
logic/operand_resolver.sv
logic/issue_control.sv
logic/issue_unit.sv
verif/issue_unit_tb.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module issue_unit_tb -f build.f -o issue_sim

output="$(./obj_dir/issue_sim)"
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
